/* rtl/dmm_consts.svh */
`ifndef DMM_CONSTS_SVH
`define DMM_CONSTS_SVH

//////////////////////////////
// widths

`define DMM_REG_W          32      // host register word
`define DMM_ADDR_W         8       // byte address into the bank
`define DMM_SEQ_DEPTH      4       // sequence table entries
`define DMM_CNT_W          24      // precharge / aperture clock counts

//////////////////////////////
// register map, byte offsets

`define DMM_ADDR_CR        8'h00   // mode in bits 2:0
`define DMM_ADDR_DIRECT    8'h04   // raw board outputs for mode 0
`define DMM_ADDR_STATUS    8'h08   // read only
`define DMM_ADDR_PRECHARGE 8'h0C
`define DMM_ADDR_SEQ_N     8'h10
`define DMM_ADDR_SEQ0      8'h14   // seq1..seq3 follow, 4 bytes apart
`define DMM_ADDR_APERTURE  8'h24

//////////////////////////////
// mode codes, cr bits 2:0

`define DMM_MODE_DIRECT    3'd0
`define DMM_MODE_SA_MOCK   3'd6    // sequencer driving the mock adc

// fixed pattern in status bits 7:0, lets the host check the link
`define DMM_STATUS_MAGIC   8'hAA

`endif

/* rtl/dmm_pkg.sv */
`include "dmm_consts.svh"

package dmm_pkg;

  //////////////////////////////
  // plain vector types

  typedef logic [`DMM_REG_W-1:0]  reg_word_t;
  typedef logic [`DMM_ADDR_W-1:0] reg_addr_t;
  typedef logic [`DMM_CNT_W-1:0]  clk_count_t;   // precharge and aperture
  typedef logic [2:0]             mode_t;
  typedef logic [5:0]             seq_entry_t;   // [5:4] pc_sw, [3:0] azmux
  typedef logic [2:0]             seq_idx_t;

  typedef seq_entry_t [`DMM_SEQ_DEPTH-1:0] seq_table_t;

  // sample acquisition fsm
  typedef enum logic [1:0] {
    SA_IDLE,
    SA_PRECHARGE,
    SA_MEASURE
  } sa_state_t;

  //////////////////////////////
  // axi4-lite channels

  typedef struct packed {
    logic                     awvalid;
    reg_addr_t                awaddr;
    logic                     wvalid;
    reg_word_t                wdata;
    logic [`DMM_REG_W/8-1:0]  wstrb;    // one bit per byte lane
    logic                     bready;
  } axil_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } axil_wr_rsp_t;

  typedef struct packed {
    logic      arvalid;
    reg_addr_t araddr;
    logic      rready;
  } axil_rd_req_t;

  typedef struct packed {
    logic       arready;
    logic       rvalid;
    reg_word_t  rdata;
    logic [1:0] rresp;
  } axil_rd_rsp_t;

  // board pins, msb first, same order as the direct register
  typedef struct packed {
    logic       adc_reset_n;      // 25
    logic       meas_complete;
    logic       spi_interrupt;
    logic       adc_cmpr_latch;   // 22
    logic       adc_sigmux;
    logic       adc_rstmux;
    logic [1:0] adc_refmux;       // 19:18
    logic [3:0] azmux;            // 17:14
    logic [1:0] pc_sw;            // 13:12
    logic [7:0] monitor;          // 11:4
    logic [3:0] leds;             // 3:0
  } board_out_t;

endpackage

/* rtl/dmm_reg_bank.sv */
`timescale 1ns/1ps
`include "dmm_consts.svh"

module dmm_reg_bank (
  input  logic                  clk,
  input  logic                  rst_i,
  input  dmm_pkg::axil_wr_req_t wr_req_i,
  output dmm_pkg::axil_wr_rsp_t wr_rsp_o,
  input  dmm_pkg::axil_rd_req_t rd_req_i,
  output dmm_pkg::axil_rd_rsp_t rd_rsp_o,
  input  logic [3:0]            hw_flags_i,          // board straps
  input  dmm_pkg::seq_idx_t     sample_idx_last_i,   // from sequencer
  output dmm_pkg::mode_t        mode_o,
  output dmm_pkg::reg_word_t    direct_o,
  output dmm_pkg::clk_count_t   precharge_o,
  output dmm_pkg::clk_count_t   aperture_o,
  output dmm_pkg::seq_idx_t     seq_n_o,
  output dmm_pkg::seq_table_t   seq_table_o
);
  import dmm_pkg::*;

  localparam int         STRB_W      = `DMM_REG_W / 8;
  localparam int         SEL_W       = $clog2(`DMM_SEQ_DEPTH);
  localparam reg_addr_t  SEQ_END     = reg_addr_t'(`DMM_ADDR_SEQ0 + 4 * `DMM_SEQ_DEPTH);
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  reg_word_t cr_q;
  reg_word_t direct_q;
  reg_word_t precharge_q;
  reg_word_t seq_n_q;
  reg_word_t aperture_q;
  reg_word_t seq_q [`DMM_SEQ_DEPTH];

  logic       alive_q;      // low in the cycle after reset, no handshakes then
  logic       bvalid_q;
  logic [1:0] bresp_q;
  logic       rvalid_q;
  reg_word_t  rdata_q;
  logic [1:0] rresp_q;

  reg_addr_t         wr_addr;
  reg_addr_t         rd_addr;
  reg_word_t         wdata;
  logic [STRB_W-1:0] wstrb;
  logic [SEL_W-1:0]  wr_seq;
  logic              wr_accept;
  logic              wr_hit;
  logic              arready;
  logic              rd_accept;
  logic              rd_hit;
  reg_word_t         rd_word;
  reg_word_t         status_word;

  function automatic logic is_seq(reg_addr_t a);
    return (a >= `DMM_ADDR_SEQ0) && (a < SEQ_END);
  endfunction

  // table slot from a byte address inside the seq window
  function automatic logic [SEL_W-1:0] seq_sel(reg_addr_t a);
    reg_addr_t off;
    off = a - `DMM_ADDR_SEQ0;
    return off[2 +: SEL_W];
  endfunction

  function automatic reg_word_t merge_bytes(reg_word_t old_w, reg_word_t new_w,
                                            logic [STRB_W-1:0] strb);
    reg_word_t res;
    res = old_w;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  //////////////////////////////
  // write channel

  assign wr_addr   = {wr_req_i.awaddr[`DMM_ADDR_W-1:2], 2'b00};   // byte lanes via wstrb
  assign wdata     = wr_req_i.wdata;
  assign wstrb     = wr_req_i.wstrb;
  assign wr_seq    = seq_sel(wr_addr);
  assign wr_accept = alive_q && wr_req_i.awvalid && wr_req_i.wvalid && !bvalid_q;

  always_comb begin
    case (wr_addr)
      `DMM_ADDR_CR, `DMM_ADDR_DIRECT, `DMM_ADDR_PRECHARGE,
      `DMM_ADDR_SEQ_N, `DMM_ADDR_APERTURE: wr_hit = 1'b1;
      default:                             wr_hit = is_seq(wr_addr);   // status ends up here
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cr_q        <= '0;
      direct_q    <= '0;
      precharge_q <= '0;
      seq_n_q     <= '0;
      aperture_q  <= '0;
      for (int i = 0; i < `DMM_SEQ_DEPTH; i++) seq_q[i] <= '0;
    end else if (wr_accept) begin
      case (wr_addr)
        `DMM_ADDR_CR:        cr_q        <= merge_bytes(cr_q, wdata, wstrb);
        `DMM_ADDR_DIRECT:    direct_q    <= merge_bytes(direct_q, wdata, wstrb);
        `DMM_ADDR_PRECHARGE: precharge_q <= merge_bytes(precharge_q, wdata, wstrb);
        `DMM_ADDR_SEQ_N:     seq_n_q     <= merge_bytes(seq_n_q, wdata, wstrb);
        `DMM_ADDR_APERTURE:  aperture_q  <= merge_bytes(aperture_q, wdata, wstrb);
        default: begin
          if (is_seq(wr_addr)) seq_q[wr_seq] <= merge_bytes(seq_q[wr_seq], wdata, wstrb);
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      alive_q  <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      alive_q <= 1'b1;
      if (wr_accept) bvalid_q <= 1'b1;
      else if (wr_req_i.bready) bvalid_q <= 1'b0;   // held until host takes it
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
  end

  //////////////////////////////
  // read channel

  // layout: [22:20] seq_n, [18:16] last sample, [11:8] flags, [7:0] magic
  assign status_word = {9'b0, seq_n_q[2:0], 1'b0, sample_idx_last_i,
                        4'b0, hw_flags_i, `DMM_STATUS_MAGIC};

  assign rd_addr   = {rd_req_i.araddr[`DMM_ADDR_W-1:2], 2'b00};
  assign arready   = alive_q && !rvalid_q;   // one read in flight
  assign rd_accept = rd_req_i.arvalid && arready;

  always_comb begin
    rd_hit  = 1'b1;
    rd_word = '0;
    case (rd_addr)
      `DMM_ADDR_CR:        rd_word = cr_q;
      `DMM_ADDR_DIRECT:    rd_word = direct_q;
      `DMM_ADDR_STATUS:    rd_word = status_word;
      `DMM_ADDR_PRECHARGE: rd_word = precharge_q;
      `DMM_ADDR_SEQ_N:     rd_word = seq_n_q;
      `DMM_ADDR_APERTURE:  rd_word = aperture_q;
      default: begin
        if (is_seq(rd_addr)) rd_word = seq_q[seq_sel(rd_addr)];
        else rd_hit = 1'b0;                 // unmapped reads as zero
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
    end else if (rd_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // data frozen while rvalid is up
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata_q <= rd_word;
      rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign wr_rsp_o.awready = wr_accept;   // aw and w taken together
  assign wr_rsp_o.wready  = wr_accept;
  assign wr_rsp_o.bvalid  = bvalid_q;
  assign wr_rsp_o.bresp   = bresp_q;
  assign rd_rsp_o.arready = arready;
  assign rd_rsp_o.rvalid  = rvalid_q;
  assign rd_rsp_o.rdata   = rdata_q;
  assign rd_rsp_o.rresp   = rresp_q;

  //////////////////////////////
  // fan-out to the datapath

  assign mode_o      = cr_q[$bits(mode_t)-1:0];
  assign direct_o    = direct_q;
  assign precharge_o = precharge_q[$bits(clk_count_t)-1:0];
  assign aperture_o  = aperture_q[$bits(clk_count_t)-1:0];
  assign seq_n_o     = seq_n_q[$bits(seq_idx_t)-1:0];

  always_comb begin
    for (int i = 0; i < `DMM_SEQ_DEPTH; i++) begin
      seq_table_o[i] = seq_q[i][$bits(seq_entry_t)-1:0];
    end
  end

endmodule

/* rtl/dmm_sample_sequencer.sv */
`timescale 1ns/1ps
`include "dmm_consts.svh"

module dmm_sample_sequencer (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                sa_trig_i,          // run level, low parks at entry 0
  input  dmm_pkg::clk_count_t precharge_i,
  input  dmm_pkg::seq_idx_t   seq_n_i,
  input  dmm_pkg::seq_table_t seq_table_i,
  input  logic                measure_valid_i,    // from adc
  output logic [3:0]          azmux_o,
  output logic [1:0]          pc_sw_o,
  output logic                adc_reset_n_o,
  output logic [3:0]          leds_o,
  output logic [7:0]          monitor_o,
  output dmm_pkg::seq_idx_t   sample_idx_last_o
);
  import dmm_pkg::*;

  localparam int SEL_W = $clog2(`DMM_SEQ_DEPTH);

  sa_state_t  state_q;
  seq_idx_t   idx_q;        // entry being acquired
  seq_idx_t   idx_last_q;   // entry of the last completed sample
  clk_count_t pc_cnt_q;     // precharge cycles left
  seq_idx_t   idx_inc;
  logic       idx_wrap;
  seq_entry_t entry;

  assign idx_inc = idx_q + 3'd1;
  // seq_n of 0 behaves as 1, never run past the table
  assign idx_wrap = (idx_inc >= seq_n_i) || (idx_inc >= seq_idx_t'(`DMM_SEQ_DEPTH));

  //////////////////////////////
  // acquisition fsm

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= SA_IDLE;
      idx_q      <= '0;
      idx_last_q <= '0;
      pc_cnt_q   <= '0;
    end else if (!sa_trig_i) begin
      state_q <= SA_IDLE;           // stopped, back to first entry
      idx_q   <= '0;
    end else begin
      case (state_q)
        SA_IDLE: begin
          state_q  <= SA_PRECHARGE;
          pc_cnt_q <= precharge_i;
        end
        SA_PRECHARGE: begin
          // exactly precharge_i cycles here, adc held in reset
          if (pc_cnt_q <= clk_count_t'(1)) state_q <= SA_MEASURE;
          else pc_cnt_q <= pc_cnt_q - 1'b1;
        end
        SA_MEASURE: begin
          if (measure_valid_i) begin
            idx_last_q <= idx_q;
            idx_q      <= idx_wrap ? seq_idx_t'(0) : idx_inc;
            state_q    <= SA_PRECHARGE;   // straight into the next entry
            pc_cnt_q   <= precharge_i;
          end
        end
        default: state_q <= SA_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // outputs

  assign entry   = seq_table_i[idx_q[SEL_W-1:0]];
  assign azmux_o = entry[3:0];
  assign pc_sw_o = entry[5:4];

  assign adc_reset_n_o     = (state_q == SA_MEASURE);   // release adc only to measure
  assign sample_idx_last_o = idx_last_q;

  always_comb begin
    leds_o = '0;
    leds_o[idx_q[SEL_W-1:0]] = 1'b1;   // one-hot entry
  end

  // scope header, bit 7 spare
  assign monitor_o = {1'b0,
                      state_q,           // 6:5
                      idx_q,             // 4:2
                      measure_valid_i,   // 1
                      adc_reset_n_o};    // 0

endmodule

/* rtl/dmm_adc_mock.sv */
`timescale 1ns/1ps

module dmm_adc_mock (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                adc_reset_n_i,   // low holds the mock idle
  input  dmm_pkg::clk_count_t aperture_i,
  output logic                measure_valid_o
);
  import dmm_pkg::*;

  clk_count_t cnt_q;     // cycles since release
  logic       done_q;    // pulse already given for this release
  logic       at_end;

  // last cycle of the aperture, aperture_i+1 cycles into the release
  assign at_end = adc_reset_n_i && !done_q && (cnt_q == aperture_i);

  //////////////////////////////
  // aperture counter

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (!adc_reset_n_i) begin
      cnt_q  <= '0;      // rearm for next release
      done_q <= 1'b0;
    end else if (at_end) begin
      done_q <= 1'b1;    // stop, wait for next reset
    end else if (!done_q) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // single cycle, from state only
  assign measure_valid_o = at_end;

endmodule

/* rtl/dmm_mode_mux.sv */
`timescale 1ns/1ps
`include "dmm_consts.svh"

module dmm_mode_mux (
  input  logic               clk,
  input  dmm_pkg::mode_t     mode_i,
  input  dmm_pkg::reg_word_t direct_i,
  input  logic [3:0]         azmux_i,      // sequencer side
  input  logic [1:0]         pc_sw_i,
  input  logic [3:0]         leds_i,
  input  logic [7:0]         monitor_i,
  output dmm_pkg::board_out_t board_o
);
  import dmm_pkg::*;

  //////////////////////////////
  // output select per mode

  always_comb begin
    board_o = '0;     // unused modes park every pin low
    case (mode_i)
      `DMM_MODE_DIRECT: begin
        // direct reg maps pin for pin
        board_o = board_out_t'(direct_i[$bits(board_out_t)-1:0]);
      end
      `DMM_MODE_SA_MOCK: begin
        // adc side stays low, no real converter here
        board_o.azmux   = azmux_i;
        board_o.pc_sw   = pc_sw_i;
        board_o.monitor = monitor_i;
        board_o.leds    = leds_i;
      end
      default: board_o = '0;
    endcase
  end

endmodule

/* rtl/dmm_top.sv */
`timescale 1ns/1ps

module dmm_top (
  input  logic                  clk,
  input  logic                  rst_i,
  input  dmm_pkg::axil_wr_req_t wr_req_i,
  output dmm_pkg::axil_wr_rsp_t wr_rsp_o,
  input  dmm_pkg::axil_rd_req_t rd_req_i,
  output dmm_pkg::axil_rd_rsp_t rd_rsp_o,
  input  logic [3:0]            hw_flags_i,
  input  logic                  sa_trig_i,
  output dmm_pkg::board_out_t   board_o
);
  import dmm_pkg::*;

  // register bank fan-out
  mode_t      mode;
  reg_word_t  direct;
  clk_count_t precharge;
  clk_count_t aperture;
  seq_idx_t   seq_n;
  seq_table_t seq_table;

  // sequencer / mock adc
  logic [3:0] sa_azmux;
  logic [1:0] sa_pc_sw;
  logic [3:0] sa_leds;
  logic [7:0] sa_monitor;
  logic       sa_adc_reset_n;
  seq_idx_t   sa_sample_idx_last;
  logic       mock_measure_valid;

  //////////////////////////////
  // host registers

  dmm_reg_bank i_reg_bank (
    .clk               (clk),
    .rst_i             (rst_i),
    .wr_req_i          (wr_req_i),
    .wr_rsp_o          (wr_rsp_o),
    .rd_req_i          (rd_req_i),
    .rd_rsp_o          (rd_rsp_o),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sa_sample_idx_last),   // back into status
    .mode_o            (mode),
    .direct_o          (direct),
    .precharge_o       (precharge),
    .aperture_o        (aperture),
    .seq_n_o           (seq_n),
    .seq_table_o       (seq_table)
  );

  //////////////////////////////
  // acquisition

  dmm_sample_sequencer i_sequencer (
    .clk               (clk),
    .rst_i             (rst_i),
    .sa_trig_i         (sa_trig_i),
    .precharge_i       (precharge),
    .seq_n_i           (seq_n),
    .seq_table_i       (seq_table),
    .measure_valid_i   (mock_measure_valid),
    .azmux_o           (sa_azmux),
    .pc_sw_o           (sa_pc_sw),
    .adc_reset_n_o     (sa_adc_reset_n),
    .leds_o            (sa_leds),
    .monitor_o         (sa_monitor),
    .sample_idx_last_o (sa_sample_idx_last)
  );

  dmm_adc_mock i_adc_mock (
    .clk             (clk),
    .rst_i           (rst_i),
    .adc_reset_n_i   (sa_adc_reset_n),
    .aperture_i      (aperture),
    .measure_valid_o (mock_measure_valid)
  );

  dmm_mode_mux i_mode_mux (
    .clk       (clk),
    .mode_i    (mode),
    .direct_i  (direct),
    .azmux_i   (sa_azmux),
    .pc_sw_i   (sa_pc_sw),
    .leds_i    (sa_leds),
    .monitor_i (sa_monitor),
    .board_o   (board_o)
  );

endmodule

/* tests/dmm_tb_assertions.sv */
`timescale 1ns/1ps
`include "dmm_consts.svh"

module dmm_tb_assertions (
  input logic                  clk,
  input logic                  rst_i,
  input dmm_pkg::axil_wr_req_t wr_req_i,
  input dmm_pkg::axil_wr_rsp_t wr_rsp_i,
  input dmm_pkg::axil_rd_req_t rd_req_i,
  input dmm_pkg::axil_rd_rsp_t rd_rsp_i,
  input dmm_pkg::mode_t        mode_i,    // internal mode wire of the top
  input dmm_pkg::board_out_t   board_i
);

  int unsigned fired_cnt = 0;   // bumped by every failing assertion

  //////////////////////////////
  // axi4-lite handshakes

  bvalid_hold: assert property (@(posedge clk) disable iff (rst_i)
    wr_rsp_i.bvalid && !wr_req_i.bready |=> wr_rsp_i.bvalid)
    else begin
      $error("bvalid dropped before bready was seen");
      fired_cnt++;
    end

  rvalid_hold: assert property (@(posedge clk) disable iff (rst_i)
    rd_rsp_i.rvalid && !rd_req_i.rready |=> rd_rsp_i.rvalid)
    else begin
      $error("rvalid dropped before rready was seen");
      fired_cnt++;
    end

  rdata_stable: assert property (@(posedge clk) disable iff (rst_i)
    rd_rsp_i.rvalid && !rd_req_i.rready |=> $stable(rd_rsp_i.rdata))
    else begin
      $error("rdata changed while rvalid was held");
      fired_cnt++;
    end

  //////////////////////////////
  // outputs

  parked_modes: assert property (@(posedge clk) disable iff (rst_i)
    (mode_i != `DMM_MODE_DIRECT) && (mode_i != `DMM_MODE_SA_MOCK) |-> board_i == '0)
    else begin
      $error("board output not parked in a disabled mode");
      fired_cnt++;
    end

  after_reset: assert property (@(posedge clk)
    $fell(rst_i) |-> !wr_rsp_i.bvalid && !rd_rsp_i.rvalid)
    else begin
      $error("response valid high right after reset");
      fired_cnt++;
    end

endmodule

bind dmm_top dmm_tb_assertions i_assertions (
  .clk      (clk),
  .rst_i    (rst_i),
  .wr_req_i (wr_req_i),
  .wr_rsp_i (wr_rsp_o),
  .rd_req_i (rd_req_i),
  .rd_rsp_i (rd_rsp_o),
  .mode_i   (mode),
  .board_i  (board_o)
);

/* tests/dmm_tb.sv */
`timescale 1ns/1ps
`include "dmm_consts.svh"

module dmm_tb;
  import dmm_pkg::*;

  localparam int         TIMEOUT_CYC = 50;
  localparam logic [1:0] OKAY        = 2'b00;
  localparam logic [1:0] SLVERR      = 2'b10;
  localparam logic [3:0] FLAGS       = 4'h6;    // board straps seen in status
  localparam int         PC_CYC      = 5;
  localparam int         AP_CYC      = 10;
  localparam int         SAMPLE_CYC  = PC_CYC + AP_CYC + 1;
  localparam int         SEQ_LEN     = 3;
  localparam seq_entry_t SEQ_E0      = 6'h15;   // pc_sw 1, azmux 5
  localparam seq_entry_t SEQ_E1      = 6'h2A;
  localparam seq_entry_t SEQ_E2      = 6'h3C;

  // one host access and what should come back
  typedef struct packed {
    logic       is_wr;
    reg_addr_t  addr;
    reg_word_t  data;
    logic [3:0] strb;
    reg_word_t  exp_data;    // rdata, or board_o after a write
    logic [1:0] exp_resp;
    logic       chk_board;
  } row_t;

  logic         clk;
  logic         rst;
  axil_wr_req_t wr_req;
  axil_wr_rsp_t wr_rsp;
  axil_rd_req_t rd_req;
  axil_rd_rsp_t rd_rsp;
  logic [3:0]   hw_flags;
  logic         sa_trig;
  board_out_t   board;

  int   seed;
  row_t rows[$];

  dmm_top i_dut (
    .clk        (clk),
    .rst_i      (rst),
    .wr_req_i   (wr_req),
    .wr_rsp_o   (wr_rsp),
    .rd_req_i   (rd_req),
    .rd_rsp_o   (rd_rsp),
    .hw_flags_i (hw_flags),
    .sa_trig_i  (sa_trig),
    .board_o    (board)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // reporting

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input string name, input reg_word_t got, input reg_word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0d ns: %s got 0x%08h expected 0x%08h",
                          $time, name, got, exp));
    end
  endtask

  // [22:20] seq_n, [18:16] last sample, [11:8] straps, [7:0] magic
  function automatic reg_word_t expected_status(input seq_idx_t seq_n, input seq_idx_t last);
    reg_word_t w;
    w        = '0;
    w[7:0]   = `DMM_STATUS_MAGIC;
    w[11:8]  = FLAGS;
    w[18:16] = last;
    w[22:20] = seq_n;
    return w;
  endfunction

  //////////////////////////////
  // axi4-lite host side, called right after a falling edge

  task automatic axi_write(input reg_addr_t addr, input reg_word_t data,
                           input logic [3:0] strb, output logic [1:0] resp,
                           output board_out_t pins);
    int n;
    wr_req.awvalid = 1'b1;
    wr_req.awaddr  = addr;
    wr_req.wvalid  = 1'b1;
    wr_req.wdata   = data;
    wr_req.wstrb   = strb;
    wr_req.bready  = 1'b0;   // response held off for one cycle
    n = 0;
    @(negedge clk);
    while (!wr_rsp.bvalid) begin   // bvalid up means aw and w were taken
      if (n == TIMEOUT_CYC) abort_run("timeout waiting for the write to be accepted");
      n++;
      @(negedge clk);
    end
    // aw and w still offered, the pending response must block them
    check("awready", 32'(wr_rsp.awready), 32'd0);
    check("wready", 32'(wr_rsp.wready), 32'd0);
    resp           = wr_rsp.bresp;
    pins           = board;   // cycle after the write was taken
    wr_req.awvalid = 1'b0;
    wr_req.wvalid  = 1'b0;
    @(negedge clk);
    check("bvalid without bready", 32'(wr_rsp.bvalid), 32'd1);
    wr_req.bready = 1'b1;
    n = 0;
    @(negedge clk);
    while (wr_rsp.bvalid) begin
      if (n == TIMEOUT_CYC) abort_run("timeout waiting for the write response to clear");
      n++;
      @(negedge clk);
    end
    wr_req.bready = 1'b0;
  endtask

  task automatic axi_read(input reg_addr_t addr, output reg_word_t data,
                          output logic [1:0] resp);
    int n;
    check("arready when idle", 32'(rd_rsp.arready), 32'd1);
    rd_req.arvalid = 1'b1;
    rd_req.araddr  = addr;
    rd_req.rready  = 1'b0;   // response held off for one cycle
    n = 0;
    @(negedge clk);
    while (!rd_rsp.rvalid) begin
      if (n == TIMEOUT_CYC) abort_run("timeout waiting for a read response");
      n++;
      @(negedge clk);
    end
    check("arready with read pending", 32'(rd_rsp.arready), 32'd0);
    data           = rd_rsp.rdata;   // stable until the next rising edge
    resp           = rd_rsp.rresp;
    rd_req.arvalid = 1'b0;
    @(negedge clk);
    check("rvalid without rready", 32'(rd_rsp.rvalid), 32'd1);
    check("rdata without rready", rd_rsp.rdata, data);
    rd_req.rready = 1'b1;
    n = 0;
    @(negedge clk);
    while (rd_rsp.rvalid) begin
      if (n == TIMEOUT_CYC) abort_run("timeout waiting for the read response to clear");
      n++;
      @(negedge clk);
    end
    rd_req.rready = 1'b0;
  endtask

  //////////////////////////////
  // stimulus table

  function automatic void add_write(input reg_addr_t addr, input reg_word_t data,
                                    input logic [3:0] strb, input logic [1:0] resp,
                                    input logic chk_board, input reg_word_t exp_board);
    rows.push_back(row_t'{1'b1, addr, data, strb, exp_board, resp, chk_board});
  endfunction

  function automatic void add_read(input reg_addr_t addr, input reg_word_t exp,
                                   input logic [1:0] resp);
    rows.push_back(row_t'{1'b0, addr, 32'd0, 4'h0, exp, resp, 1'b0});
  endfunction

  task automatic build_table();
    reg_word_t r [8];
    reg_word_t d;
    for (int i = 0; i < 8; i++) r[i] = $random(seed);
    // plain readback
    add_write(`DMM_ADDR_CR, r[0], 4'hF, OKAY, 1'b0, '0);
    add_read(`DMM_ADDR_CR, r[0], OKAY);
    add_write(`DMM_ADDR_PRECHARGE, r[1], 4'hF, OKAY, 1'b0, '0);
    add_read(`DMM_ADDR_PRECHARGE, r[1], OKAY);
    add_write(`DMM_ADDR_PRECHARGE, 32'hC3C3_C3C3, 4'b1010, OKAY, 1'b0, '0);   // lanes 3, 1
    add_read(`DMM_ADDR_PRECHARGE, {8'hC3, r[1][23:16], 8'hC3, r[1][7:0]}, OKAY);
    add_write(`DMM_ADDR_SEQ_N, r[2], 4'hF, OKAY, 1'b0, '0);
    add_read(`DMM_ADDR_SEQ_N, r[2], OKAY);
    for (int i = 0; i < `DMM_SEQ_DEPTH; i++) begin
      add_write(reg_addr_t'(`DMM_ADDR_SEQ0 + 4 * i), r[3+i], 4'hF, OKAY, 1'b0, '0);
      add_read(reg_addr_t'(`DMM_ADDR_SEQ0 + 4 * i), r[3+i], OKAY);
    end
    add_write(`DMM_ADDR_APERTURE, r[7], 4'hF, OKAY, 1'b0, '0);
    add_read(`DMM_ADDR_APERTURE, r[7], OKAY);
    // error responses, status stays read only
    add_write(`DMM_ADDR_STATUS, 32'hFFFF_FFFF, 4'hF, SLVERR, 1'b0, '0);
    add_read(`DMM_ADDR_STATUS, expected_status(r[2][2:0], 3'd0), OKAY);
    add_read(8'h40, '0, SLVERR);
    add_write(8'h44, r[0], 4'hF, SLVERR, 1'b0, '0);
    // direct mode, pins follow the register
    add_write(`DMM_ADDR_CR, 32'(`DMM_MODE_DIRECT), 4'hF, OKAY, 1'b1, '0);
    for (int i = 0; i < 4; i++) begin
      d = $random(seed);
      add_write(`DMM_ADDR_DIRECT, d, 4'hF, OKAY, 1'b1, {6'b0, d[25:0]});
    end
    add_write(`DMM_ADDR_CR, 32'd1, 4'hF, OKAY, 1'b1, '0);   // parked
    add_write(`DMM_ADDR_CR, 32'd5, 4'hF, OKAY, 1'b1, '0);
    // sequencer setup, mode 6 goes last
    add_write(`DMM_ADDR_SEQ_N, 32'(SEQ_LEN), 4'hF, OKAY, 1'b0, '0);
    add_write(`DMM_ADDR_SEQ0, 32'(SEQ_E0), 4'hF, OKAY, 1'b0, '0);
    add_write(`DMM_ADDR_SEQ0 + 8'd4, 32'(SEQ_E1), 4'hF, OKAY, 1'b0, '0);
    add_write(`DMM_ADDR_SEQ0 + 8'd8, 32'(SEQ_E2), 4'hF, OKAY, 1'b0, '0);
    add_write(`DMM_ADDR_PRECHARGE, 32'(PC_CYC), 4'hF, OKAY, 1'b0, '0);
    add_write(`DMM_ADDR_APERTURE, 32'(AP_CYC), 4'hF, OKAY, 1'b0, '0);
    // idle sequencer: entry 0, led 0, monitor all low
    add_write(`DMM_ADDR_CR, 32'(`DMM_MODE_SA_MOCK), 4'hF, OKAY, 1'b1,
              {14'b0, SEQ_E0[3:0], SEQ_E0[5:4], 8'h00, 4'b0001});
  endtask

  //////////////////////////////
  // sequencer checks

  task automatic watch_sequence(output int done_cnt);
    seq_entry_t order [6];
    seq_entry_t cur;
    seq_entry_t now;
    int         seen;
    int         run_len;
    order = '{SEQ_E0, SEQ_E1, SEQ_E2, SEQ_E0, SEQ_E1, SEQ_E2};
    cur   = {board.pc_sw, board.azmux};
    check("board_o entry at start", 32'(cur), 32'(order[0]));
    seen    = 1;
    run_len = 0;
    while (seen < 6) begin
      @(negedge clk);
      run_len++;
      if (run_len > 2 * SAMPLE_CYC) abort_run("timeout waiting for the next sequence entry");
      check("board_o adc fields", 32'(board[25:18]), 32'd0);
      now = {board.pc_sw, board.azmux};
      if (now != cur) begin
        // first entry also holds the idle cycle
        check("entry length", 32'(run_len), 32'(seen == 1 ? SAMPLE_CYC + 1 : SAMPLE_CYC));
        check("board_o entry", 32'(now), 32'(order[seen]));
        check("board_o leds", 32'(board.leds), 32'(4'b0001 << (seen % SEQ_LEN)));
        check("board_o monitor index", 32'(board.monitor[4:2]), 32'(seen % SEQ_LEN));
        cur     = now;
        seen    = seen + 1;
        run_len = 0;
      end
    end
    done_cnt = seen - 1;   // one completed sample per change
  endtask

  task automatic stop_and_hold();
    int n;
    sa_trig = 1'b0;
    n = 0;
    @(negedge clk);
    while ({board.pc_sw, board.azmux} != SEQ_E0) begin
      if (n == TIMEOUT_CYC) abort_run("timeout waiting for entry 0 after the stop");
      n++;
      @(negedge clk);
    end
    for (int i = 0; i < 2 * SAMPLE_CYC; i++) begin
      check("board_o entry after stop", 32'({board.pc_sw, board.azmux}), 32'(SEQ_E0));
      @(negedge clk);
    end
  endtask

  //////////////////////////////
  // main flow

  initial begin
    row_t       row;
    logic [1:0] resp;
    reg_word_t  rdata;
    board_out_t pins;
    int         done_cnt;
    seed     = 74960;
    rst      = 1'b1;
    wr_req   = '0;
    rd_req   = '0;
    hw_flags = FLAGS;
    sa_trig  = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    build_table();
    foreach (rows[i]) begin
      row = rows[i];
      if (row.is_wr) begin
        axi_write(row.addr, row.data, row.strb, resp, pins);
        check($sformatf("bresp (row %0d)", i), 32'(resp), 32'(row.exp_resp));
        if (row.chk_board) check($sformatf("board_o (row %0d)", i), 32'(pins), row.exp_data);
      end else begin
        axi_read(row.addr, rdata, resp);
        check($sformatf("rdata (row %0d)", i), rdata, row.exp_data);
        check($sformatf("rresp (row %0d)", i), 32'(resp), 32'(row.exp_resp));
      end
    end
    sa_trig = 1'b1;
    watch_sequence(done_cnt);
    stop_and_hold();
    axi_read(`DMM_ADDR_STATUS, rdata, resp);
    check("status after stop", rdata,
          expected_status(seq_idx_t'(SEQ_LEN), seq_idx_t'((done_cnt - 1) % SEQ_LEN)));
    check("rresp status", 32'(resp), 32'(OKAY));
    if (i_dut.i_assertions.fired_cnt != 0) begin
      abort_run("a concurrent assertion failed during the run");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

/* files.f */
+incdir+rtl
rtl/dmm_pkg.sv
rtl/dmm_reg_bank.sv
rtl/dmm_sample_sequencer.sv
rtl/dmm_adc_mock.sv
rtl/dmm_mode_mux.sv
rtl/dmm_top.sv
tests/dmm_tb_assertions.sv
tests/dmm_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dmm testbench with verilator
# the log decides pass or fail

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module dmm_tb --Mdir "$OBJ" -o vdmm_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past an assertion error so the testbench reports it
"./$OBJ/vdmm_tb" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
